/* hdl/mem_driver_pkg.sv */
// ======================================================================
// Widths, encodings and bundles shared by the memory driver and its testbench.
// Lines are cut to 64 bits and addresses are 32-bit line addresses.
// ======================================================================

package mem_driver_pkg;

    // ==================================================================
    // Widths
    // ==================================================================

    // Address of one line, not a byte address
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;

    // Each read tag names one reorder buffer slot
    localparam int TAG_W = 3;
    localparam int ROB_DEPTH = 1 << TAG_W;

    typedef logic [ADDR_W-1:0] t_line_addr;
    typedef logic [DATA_W-1:0] t_line_data;
    typedef logic [TAG_W-1:0]  t_tag;

    // ==================================================================
    // Request side encodings
    // ==================================================================

    // The S and M forms allocate in the host cache and the I forms bypass it
    typedef enum logic [1:0] {
        REQ_RDLINE_S = 2'b00,
        REQ_RDLINE_I = 2'b01,
        REQ_WRLINE_M = 2'b10,
        REQ_WRLINE_I = 2'b11
    } t_req_opcode;

    // VC_VA leaves the choice of channel to the FIU
    // VC_VL0 is the one channel that keeps requests in order
    typedef enum logic [1:0] {
        VC_VA  = 2'b00,
        VC_VL0 = 2'b01
    } t_vc_sel;

    typedef struct packed {
        t_req_opcode opcode;
        t_vc_sel     vc;
        t_line_addr  addr;
        t_tag        tag;
    } t_req_hdr;

    typedef struct packed {
        logic     valid;
        t_req_hdr hdr;
    } t_c0_tx;

    typedef struct packed {
        logic       valid;
        t_req_hdr   hdr;
        t_line_data data;
    } t_c1_tx;

    // ==================================================================
    // Response side encodings
    // ==================================================================

    // RSP_NONE marks an idle cycle on a response channel
    typedef enum logic [1:0] {
        RSP_NONE   = 2'b00,
        RSP_RDLINE = 2'b01,
        RSP_WRLINE = 2'b10
    } t_rsp_type;

    typedef struct packed {
        t_rsp_type  rsp_type;
        t_tag       tag;
        t_line_data data;
    } t_c0_rx;

    // One write response may complete up to two lines
    typedef struct packed {
        t_rsp_type  rsp_type;
        logic [1:0] count;
    } t_c1_rx;

    typedef struct packed {
        logic       valid;
        t_line_data data;
    } t_rd_rsp;

endpackage

/* hdl/mem_req_encoder.sv */
// ======================================================================
// Maps client reads and writes onto FIU request headers with no added cycles.
// The FIU must accept any valid request, so almost-full drops the ready.
// ======================================================================
`timescale 1ns/10ps

module mem_req_encoder
(
    input  logic                        clk,
    input  logic                        reset,

    // Client read request
    input  logic                        rd_req_valid,
    input  mem_driver_pkg::t_line_addr  rd_req_addr,
    input  logic                        rd_req_cached,
    input  logic                        rd_req_check_order,
    output logic                        rd_req_ready,

    // Client write request
    input  logic                        wr_req_valid,
    input  mem_driver_pkg::t_line_addr  wr_req_addr,
    input  mem_driver_pkg::t_line_data  wr_req_data,
    input  logic                        wr_req_cached,
    input  logic                        wr_req_check_order,
    output logic                        wr_req_ready,

    // FIU flow control
    input  logic                        c0_almost_full,
    input  logic                        c1_almost_full,

    // Tag allocation from the reorder buffer
    input  logic                        rob_full,
    input  mem_driver_pkg::t_tag        alloc_tag,
    output logic                        alloc_valid,

    // FIU request channels
    output mem_driver_pkg::t_c0_tx      fiu_c0_tx,
    output mem_driver_pkg::t_c1_tx      fiu_c1_tx
);

    // Set one cycle after reset is released
    // The readies stay low on that first cycle so the FIU sees a clean idle edge
    logic rst_done;

    always_ff @(posedge clk)
    begin
        if (!reset)
            rst_done <= 1'b0;
        else
            rst_done <= 1'b1;
    end

    // A read also needs a free buffer slot to hold its response
    assign rd_req_ready = reset && rst_done && !c0_almost_full && !rob_full;
    assign wr_req_ready = reset && rst_done && !c1_almost_full;

    // Each accepted read takes the tag at the buffer tail
    assign alloc_valid = rd_req_valid && rd_req_ready;

    // ==================================================================
    // Header generation
    // ==================================================================

    always_comb
    begin
        fiu_c0_tx.valid = alloc_valid;
        fiu_c0_tx.hdr.opcode = rd_req_cached ? mem_driver_pkg::REQ_RDLINE_S :
                                               mem_driver_pkg::REQ_RDLINE_I;
        // Reads that must stay ordered against other traffic use the ordered channel
        fiu_c0_tx.hdr.vc = rd_req_check_order ? mem_driver_pkg::VC_VL0 :
                                                mem_driver_pkg::VC_VA;
        fiu_c0_tx.hdr.addr = rd_req_addr;
        fiu_c0_tx.hdr.tag = alloc_tag;
    end

    // Write acks are counts only, so writes never need a tag
    // The order hint is accepted but writes always leave the channel to the FIU
    always_comb
    begin
        fiu_c1_tx.valid = wr_req_valid && wr_req_ready;
        fiu_c1_tx.hdr.opcode = wr_req_cached ? mem_driver_pkg::REQ_WRLINE_M :
                                               mem_driver_pkg::REQ_WRLINE_I;
        fiu_c1_tx.hdr.vc = mem_driver_pkg::VC_VA;
        fiu_c1_tx.hdr.addr = wr_req_addr;
        fiu_c1_tx.hdr.tag = '0;
        fiu_c1_tx.data = wr_req_data;
    end

endmodule

/* hdl/read_reorder_buffer.sv */
// ======================================================================
// Holds out-of-order read data by tag and releases it in request order.
// At most one response leaves per cycle; the client cannot stall it.
// ======================================================================
`timescale 1ns/10ps

module read_reorder_buffer
(
    input  logic                        clk,
    input  logic                        reset,

    // Allocation from the request side
    input  logic                        alloc_valid,
    output mem_driver_pkg::t_tag        alloc_tag,
    output logic                        rob_full,

    // Fill from the response decoder
    input  logic                        fill_valid,
    input  mem_driver_pkg::t_tag        fill_tag,
    input  mem_driver_pkg::t_line_data  fill_data,

    // Ordered response to the client
    output mem_driver_pkg::t_rd_rsp     rd_rsp
);

    // ==================================================================
    // Storage and pointers
    // ==================================================================

    // Pointers carry one extra bit so that full and empty differ
    logic [mem_driver_pkg::TAG_W:0]       head;
    logic [mem_driver_pkg::TAG_W:0]       tail;

    // One flag per slot, set once its data has arrived and not yet released
    logic [mem_driver_pkg::ROB_DEPTH-1:0] filled;

    mem_driver_pkg::t_line_data           data_mem [mem_driver_pkg::ROB_DEPTH];

    mem_driver_pkg::t_tag                 head_idx;
    logic                                 bypass;
    logic                                 head_release;

    logic                                 rsp_valid;
    mem_driver_pkg::t_line_data           rsp_data;

    assign head_idx = head[mem_driver_pkg::TAG_W-1:0];

    // The next tag handed out is the tail slot
    assign alloc_tag = tail[mem_driver_pkg::TAG_W-1:0];

    // Full when the index bits match and the wrap bits differ
    assign rob_full = (tail[mem_driver_pkg::TAG_W] != head[mem_driver_pkg::TAG_W]) &&
                      (alloc_tag == head_idx);

    // A fill aimed at the head slot goes straight out on the next edge
    // This keeps the minimum FIU-to-client latency at two cycles
    assign bypass = fill_valid && (fill_tag == head_idx);
    assign head_release = filled[head_idx] || bypass;

    // ==================================================================
    // Control state
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            head <= '0;
            tail <= '0;
            filled <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            if (alloc_valid)
                tail <= tail + 1'b1;

            // A bypassed fill never needs its flag, it leaves at once
            if (fill_valid && !bypass)
                filled[fill_tag] <= 1'b1;

            // A fill that is not bypassed can never target the head slot
            if (head_release)
            begin
                filled[head_idx] <= 1'b0;
                head <= head + 1'b1;
            end

            rsp_valid <= head_release;
        end
    end

    // ==================================================================
    // Data path
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (fill_valid)
            data_mem[fill_tag] <= fill_data;

        if (head_release)
            rsp_data <= bypass ? fill_data : data_mem[head_idx];
    end

    assign rd_rsp = '{valid: rsp_valid, data: rsp_data};

endmodule

/* hdl/fiu_rsp_decoder.sv */
// ======================================================================
// Registers both FIU response channels and splits them by response type.
// Read fills go to the reorder buffer; write counts go straight to the client.
// ======================================================================
`timescale 1ns/10ps

module fiu_rsp_decoder
(
    input  logic                        clk,
    input  logic                        reset,

    // FIU response channels
    input  mem_driver_pkg::t_c0_rx      fiu_c0_rx,
    input  mem_driver_pkg::t_c1_rx      fiu_c1_rx,

    // Fill toward the reorder buffer
    output logic                        fill_valid,
    output mem_driver_pkg::t_tag        fill_tag,
    output mem_driver_pkg::t_line_data  fill_data,

    // Lines completed this cycle, 0 to 2
    output logic [1:0]                  wr_ack
);

    logic c0_is_rd;
    logic c1_is_wr;

    // Anything other than a read line on c0 is ignored
    assign c0_is_rd = (fiu_c0_rx.rsp_type == mem_driver_pkg::RSP_RDLINE);

    // Only a write response on c1 carries a valid count
    assign c1_is_wr = (fiu_c1_rx.rsp_type == mem_driver_pkg::RSP_WRLINE);

    // ==================================================================
    // Response registers
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            fill_valid <= 1'b0;
            wr_ack <= 2'd0;
        end
        else
        begin
            fill_valid <= c0_is_rd;
            // An idle or foreign c1 cycle reports no completions
            wr_ack <= c1_is_wr ? fiu_c1_rx.count : 2'd0;
        end
    end

    // Tag and data only matter while fill_valid is high
    always_ff @(posedge clk)
    begin
        if (c0_is_rd)
        begin
            fill_tag <= fiu_c0_rx.tag;
            fill_data <= fiu_c0_rx.data;
        end
    end

endmodule

/* hdl/mem_driver_top.sv */
// ======================================================================
// Client memory driver between a simple client and the FIU host link.
// The client must accept every read response; rd_rsp has no ready.
// ======================================================================
`timescale 1ns/10ps

module mem_driver_top
(
    input  logic                        clk,
    input  logic                        reset,

    // Client read request and response
    input  logic                        rd_req_valid,
    input  mem_driver_pkg::t_line_addr  rd_req_addr,
    input  logic                        rd_req_cached,
    input  logic                        rd_req_check_order,
    output logic                        rd_req_ready,
    output mem_driver_pkg::t_rd_rsp     rd_rsp,

    // Client write request and ack count
    input  logic                        wr_req_valid,
    input  mem_driver_pkg::t_line_addr  wr_req_addr,
    input  mem_driver_pkg::t_line_data  wr_req_data,
    input  logic                        wr_req_cached,
    input  logic                        wr_req_check_order,
    output logic                        wr_req_ready,
    output logic [1:0]                  wr_ack,

    // FIU side
    output mem_driver_pkg::t_c0_tx      fiu_c0_tx,
    output mem_driver_pkg::t_c1_tx      fiu_c1_tx,
    input  logic                        c0_almost_full,
    input  logic                        c1_almost_full,
    input  mem_driver_pkg::t_c0_rx      fiu_c0_rx,
    input  mem_driver_pkg::t_c1_rx      fiu_c1_rx
);

    // Tag allocation between the encoder and the buffer
    logic                        alloc_valid;
    mem_driver_pkg::t_tag        alloc_tag;
    logic                        rob_full;

    // Read fills from the decoder into the buffer
    logic                        fill_valid;
    mem_driver_pkg::t_tag        fill_tag;
    mem_driver_pkg::t_line_data  fill_data;

    mem_req_encoder u_encoder
    (
        .clk, .reset,
        .rd_req_valid, .rd_req_addr, .rd_req_cached, .rd_req_check_order, .rd_req_ready,
        .wr_req_valid, .wr_req_addr, .wr_req_data, .wr_req_cached, .wr_req_check_order,
        .wr_req_ready, .c0_almost_full, .c1_almost_full,
        .rob_full, .alloc_tag, .alloc_valid, .fiu_c0_tx, .fiu_c1_tx
    );

    read_reorder_buffer u_rob
    (
        .clk, .reset, .alloc_valid, .alloc_tag, .rob_full,
        .fill_valid, .fill_tag, .fill_data, .rd_rsp
    );

    fiu_rsp_decoder u_decoder
    (
        .clk, .reset, .fiu_c0_rx, .fiu_c1_rx,
        .fill_valid, .fill_tag, .fill_data, .wr_ack
    );

endmodule

/* tb/mem_driver_tb.sv */
// ======================================================================
// Random traffic against a FIU model that answers reads out of order.
// Addresses stay in a 16-line window so that reads often hit earlier writes.
// ======================================================================
`timescale 1ns/10ps

module mem_driver_tb;

    localparam int N_OPS = 400;
    localparam int MAX_LAT = 20;
    // Low nibble is 0 so addr[3:0] indexes both memory models
    localparam mem_driver_pkg::t_line_addr BASE = 32'h0003_7c40;

    typedef struct packed {
        mem_driver_pkg::t_tag       tag;
        mem_driver_pkg::t_line_data data;
        int                         due;
    } t_pend;

    logic clk = 1'b0;
    logic reset;
    logic rd_req_valid, rd_req_cached, rd_req_check_order, rd_req_ready;
    logic wr_req_valid, wr_req_cached, wr_req_check_order, wr_req_ready;
    logic c0_almost_full, c1_almost_full;
    logic [1:0] wr_ack;
    mem_driver_pkg::t_line_addr rd_req_addr, wr_req_addr;
    mem_driver_pkg::t_line_data wr_req_data;
    mem_driver_pkg::t_rd_rsp    rd_rsp;
    mem_driver_pkg::t_c0_tx     fiu_c0_tx;
    mem_driver_pkg::t_c1_tx     fiu_c1_tx;
    mem_driver_pkg::t_c0_rx     fiu_c0_rx;
    mem_driver_pkg::t_c1_rx     fiu_c1_rx;

    // FIU model state and reference model state are kept apart
    mem_driver_pkg::t_line_data fiu_mem [16];
    mem_driver_pkg::t_line_data ref_mem [16];
    mem_driver_pkg::t_line_data exp_q [$];
    mem_driver_pkg::t_tag       tag_q [$];
    t_pend                      pend_q [$];
    logic [mem_driver_pkg::ROB_DEPTH-1:0] tag_busy = '0;

    // Tags are handed out in request order from the buffer tail
    mem_driver_pkg::t_tag       next_tag = '0;

    logic [31:0] seed = 32'hcaa9;
    int cyc = 0;
    int ops = 0;
    int af0 = 0;
    int af1 = 0;
    int wr_pend = 0;
    int wr_count = 0;
    int ack_sum = 0;
    int outstanding = 0;
    int full_seen = 0;
    logic rd_hs = 1'b0;
    logic wr_hs = 1'b0;

    mem_driver_top uut
    (
        .clk, .reset,
        .rd_req_valid, .rd_req_addr, .rd_req_cached, .rd_req_check_order, .rd_req_ready,
        .rd_rsp, .wr_req_valid, .wr_req_addr, .wr_req_data, .wr_req_cached,
        .wr_req_check_order, .wr_req_ready, .wr_ack, .fiu_c0_tx, .fiu_c1_tx,
        .c0_almost_full, .c1_almost_full, .fiu_c0_rx, .fiu_c1_rx
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    // Watchdog sized for the worst case of every op waiting out the full latency
    initial
    begin
        #(N_OPS * (MAX_LAT + 10) * 20);
        fail_run("Run timed out before all requests completed");
    end

    // ==================================================================
    // Helpers and compare tasks
    // ==================================================================

    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // Initial line contents depend on every address bit
    function automatic mem_driver_pkg::t_line_data init_line(mem_driver_pkg::t_line_addr addr);
        return {addr ^ 32'ha5a5_0f0f, ~addr};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_ctrl(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_hdr(input string name, input mem_driver_pkg::t_req_hdr got,
                             input mem_driver_pkg::t_req_hdr exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_wr_data(input mem_driver_pkg::t_line_data got,
                                 input mem_driver_pkg::t_line_data exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] fiu_c1_tx.data got %h expected %h", got, exp));
    endtask

    task automatic check_rd_rsp(input mem_driver_pkg::t_line_data got,
                                input mem_driver_pkg::t_line_data exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] rd_rsp.data got %h expected %h", got, exp));
    endtask

    task automatic check_wr_ack_total(input int got, input int exp);
        if (got != exp)
            fail_run($sformatf("[ERROR] wr_ack total got %h expected %h", got, exp));
    endtask

    // ==================================================================
    // Stimulus and FIU responses driven 2 ns after each rising edge
    // ==================================================================

    task automatic drive_cycle();
        logic [31:0] r;
        logic [31:0] r2;
        int i;
        int idx;
        r = xorshift();
        r2 = xorshift();
        // A request that transferred on the last edge is dropped
        if (rd_hs)
            rd_req_valid = 1'b0;
        if (wr_hs)
            wr_req_valid = 1'b0;
        if (!rd_req_valid && !wr_req_valid && ops < N_OPS && r[2:0] != 3'd0)
        begin
            ops++;
            // Three reads in four, so the buffer fills up now and then
            if (r[4:3] != 2'b00)
            begin
                rd_req_valid = 1'b1;
                rd_req_addr = BASE + r[8:5];
                rd_req_cached = r[9];
                rd_req_check_order = r[10];
            end
            else
            begin
                wr_req_valid = 1'b1;
                wr_req_addr = BASE + r[8:5];
                wr_req_data[63:32] = xorshift();
                wr_req_data[31:0] = xorshift();
                wr_req_cached = r[11];
                wr_req_check_order = r[12];
            end
        end
        // Almost-full bursts of 2 to 9 cycles on each channel
        if (af0 == 0 && r[20:16] == 5'd0)
            af0 = 2 + r[23:21];
        if (af1 == 0 && r[28:24] == 5'd0)
            af1 = 2 + r[31:29];
        c0_almost_full = (af0 != 0);
        c1_almost_full = (af1 != 0);
        if (af0 != 0)
            af0--;
        if (af1 != 0)
            af1--;
        // The oldest read whose latency has run out answers first
        fiu_c0_rx = '0;
        idx = -1;
        for (i = pend_q.size() - 1; i >= 0; i--)
            if (pend_q[i].due <= cyc)
                idx = i;
        if (idx >= 0)
        begin
            fiu_c0_rx.rsp_type = mem_driver_pkg::RSP_RDLINE;
            fiu_c0_rx.tag = pend_q[idx].tag;
            fiu_c0_rx.data = pend_q[idx].data;
            pend_q.delete(idx);
        end
        fiu_c1_rx = '0;
        if (wr_pend > 0 && r2[0])
        begin
            fiu_c1_rx.rsp_type = mem_driver_pkg::RSP_WRLINE;
            fiu_c1_rx.count = (wr_pend >= 2 && r2[1]) ? 2'd2 : 2'd1;
            wr_pend -= fiu_c1_rx.count;
        end
    endtask

    initial
    begin
        reset = 1'b0;
        {rd_req_valid, rd_req_cached, rd_req_check_order} = '0;
        {wr_req_valid, wr_req_cached, wr_req_check_order} = '0;
        rd_req_addr = '0;
        wr_req_addr = '0;
        wr_req_data = '0;
        c0_almost_full = 1'b0;
        c1_almost_full = 1'b0;
        fiu_c0_rx = '0;
        fiu_c1_rx = '0;
        for (int i = 0; i < 16; i++)
        begin
            fiu_mem[i] = init_line(BASE + i);
            ref_mem[i] = init_line(BASE + i);
        end
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b1;
        while (ops < N_OPS || rd_req_valid || wr_req_valid || exp_q.size() != 0 ||
               pend_q.size() != 0 || wr_pend != 0)
        begin
            @(posedge clk);
            #2;
            drive_cycle();
        end
        // Let the last write response register, then idle both channels
        @(posedge clk);
        #2;
        fiu_c0_rx = '0;
        fiu_c1_rx = '0;
        repeat (4) @(posedge clk);
        check_wr_ack_total(ack_sum, wr_count);
        if (full_seen == 0)
            fail_run("Reorder buffer never filled, read back-pressure was not exercised");
        else
        begin
            $display("test passed");
            $finish;
        end
    end

    // ==================================================================
    // Monitor sampled mid-cycle while every signal is stable
    // ==================================================================

    always @(negedge clk)
    begin : monitor
        mem_driver_pkg::t_req_hdr exp_hdr;
        t_pend p;
        rd_hs = rd_req_valid && rd_req_ready;
        wr_hs = wr_req_valid && wr_req_ready;
        // Reset cycles and the first cycle after release are fully idle
        if (cyc >= 1 && cyc <= 4)
        begin
            check_ctrl("rd_req_ready", rd_req_ready, 2'd0);
            check_ctrl("wr_req_ready", wr_req_ready, 2'd0);
            check_ctrl("rd_rsp.valid", rd_rsp.valid, 2'd0);
            check_ctrl("wr_ack", wr_ack, 2'd0);
            check_ctrl("fiu_c0_tx.valid", fiu_c0_tx.valid, 2'd0);
            check_ctrl("fiu_c1_tx.valid", fiu_c1_tx.valid, 2'd0);
        end
        if (c0_almost_full)
            check_ctrl("rd_req_ready", rd_req_ready, 2'd0);
        if (c1_almost_full)
            check_ctrl("wr_req_ready", wr_req_ready, 2'd0);
        check_ctrl("fiu_c0_tx.valid", fiu_c0_tx.valid, rd_hs);
        check_ctrl("fiu_c1_tx.valid", fiu_c1_tx.valid, wr_hs);
        // A release frees its slot in the same cycle that rd_rsp shows it
        if (rd_rsp.valid === 1'b1)
        begin
            if (exp_q.size() == 0)
                fail_run("Read response arrived with no read outstanding");
            check_rd_rsp(rd_rsp.data, exp_q.pop_front());
            tag_busy[tag_q.pop_front()] = 1'b0;
            outstanding--;
        end
        if (outstanding == mem_driver_pkg::ROB_DEPTH)
        begin
            full_seen++;
            check_ctrl("rd_req_ready", rd_req_ready, 2'd0);
        end
        if (rd_hs)
        begin
            exp_hdr.opcode = rd_req_cached ? mem_driver_pkg::REQ_RDLINE_S :
                                             mem_driver_pkg::REQ_RDLINE_I;
            exp_hdr.vc = rd_req_check_order ? mem_driver_pkg::VC_VL0 : mem_driver_pkg::VC_VA;
            exp_hdr.addr = rd_req_addr;
            exp_hdr.tag = next_tag;
            check_hdr("fiu_c0_tx.hdr", fiu_c0_tx.hdr, exp_hdr);
            if (tag_busy[fiu_c0_tx.hdr.tag])
                fail_run("Read tag handed out again while still outstanding");
            tag_busy[fiu_c0_tx.hdr.tag] = 1'b1;
            tag_q.push_back(fiu_c0_tx.hdr.tag);
            next_tag = next_tag + 1'b1;
            exp_q.push_back(ref_mem[rd_req_addr[3:0]]);
            outstanding++;
            // The FIU reads its memory before any write on the same edge
            p.tag = fiu_c0_tx.hdr.tag;
            p.data = fiu_mem[fiu_c0_tx.hdr.addr[3:0]];
            p.due = cyc + 1 + (xorshift() % MAX_LAT);
            pend_q.push_back(p);
        end
        if (wr_hs)
        begin
            exp_hdr.opcode = wr_req_cached ? mem_driver_pkg::REQ_WRLINE_M :
                                             mem_driver_pkg::REQ_WRLINE_I;
            exp_hdr.vc = mem_driver_pkg::VC_VA;
            exp_hdr.addr = wr_req_addr;
            exp_hdr.tag = '0;
            check_hdr("fiu_c1_tx.hdr", fiu_c1_tx.hdr, exp_hdr);
            check_wr_data(fiu_c1_tx.data, wr_req_data);
            ref_mem[wr_req_addr[3:0]] = wr_req_data;
            fiu_mem[fiu_c1_tx.hdr.addr[3:0]] = fiu_c1_tx.data;
            wr_pend++;
            wr_count++;
        end
        ack_sum += wr_ack;
    end

endmodule

/* mem_driver_top.f */
hdl/mem_driver_pkg.sv
hdl/mem_req_encoder.sv
hdl/read_reorder_buffer.sv
hdl/fiu_rsp_decoder.sv
hdl/mem_driver_top.sv
tb/mem_driver_tb.sv
